// ==== radar_pkg.sv ====
package radar_pkg;

  // one I or Q sample from the DDS or the ADC
  typedef logic signed [15:0] sample_t;

  // I in the upper half, Q in the lower half
  typedef logic [31:0] iq_t;

  // phase accumulator and frequency words
  typedef logic [31:0] phase_t;

  // sample counter, chirp length and timestamp
  typedef logic [31:0] count_t;

  // one word on the capture stream
  typedef logic [63:0] cap_word_t;

  // source select for each half of a capture word
  typedef enum logic [1:0] {
    route_adc          = 2'd0,
    route_dac          = 2'd1,
    route_sample_count = 2'd2,
    route_timestamp    = 2'd3
  } route_t;

  // cycles the loopback needs to settle after chirp start or capture stop
  localparam int unsigned SETTLE_CYCLES = 2;

  // Q leads I by 90 degrees
  localparam phase_t QUARTER_TURN = 32'h4000_0000;

  // output buffer depth is a power of two
  localparam int unsigned BUF_DEPTH = 16;
  localparam int unsigned BUF_AW = $clog2(BUF_DEPTH);

endpackage

// ==== chirp_gen.sv ====
`timescale 1ns/10ps

module chirp_gen
  import radar_pkg::*;
(
  input  logic    clk_245_76MHz,
  input  logic    cpu_reset,
  input  logic    chirp_init_i,
  input  logic    chirp_enable_i,
  input  phase_t  freq_offset_i,
  input  phase_t  freq_step_i,
  input  count_t  count_max_i,
  output sample_t dds_i_o,
  output sample_t dds_q_o,
  output logic    dds_valid_o,
  output logic    chirp_ready_o,
  output logic    chirp_active_o,
  output logic    chirp_done_o
);

  typedef enum logic [1:0] {
    s_idle = 2'd0,
    s_run  = 2'd1,
    s_done = 2'd2
  } state_t;

  state_t state;
  count_t samples_left;
  phase_t freq;
  phase_t phase;
  phase_t phase_q;

  // sequencing
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      state        <= s_idle;
      samples_left <= '0;
    end else begin
      case (state)
        s_idle: begin
          // a zero length chirp is ignored
          if (chirp_init_i && chirp_enable_i && (count_max_i != '0)) begin
            state        <= s_run;
            samples_left <= count_max_i;
          end
        end
        s_run: begin
          samples_left <= samples_left - 1'b1;
          if (samples_left == count_t'(1)) begin
            state <= s_done;
          end
        end
        s_done: begin
          state <= s_idle;
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  // start values sit ready while idle, so the first sample has phase zero
  always_ff @(posedge clk_245_76MHz) begin
    if (state == s_idle) begin
      freq  <= freq_offset_i;
      phase <= '0;
    end else if (state == s_run) begin
      phase <= phase + freq;
      freq  <= freq + freq_step_i;
    end
  end

  assign phase_q = phase + QUARTER_TURN;

  // sawtooth outputs from the top of the accumulator
  assign dds_i_o = sample_t'(phase[31:16]);
  assign dds_q_o = sample_t'(phase_q[31:16]);

  assign dds_valid_o    = (state == s_run);
  assign chirp_active_o = (state == s_run);
  assign chirp_ready_o  = (state == s_idle);
  assign chirp_done_o   = (state == s_done);

  // a running chirp always has samples left to produce
  a_run_has_samples: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      (state == s_run) |-> (samples_left != '0)
  );

endmodule

// ==== loopback_delay.sv ====
`timescale 1ns/10ps

module loopback_delay
  import radar_pkg::*;
(
  input  logic    clk_245_76MHz,
  input  sample_t dds_i_i,
  input  sample_t dds_q_i,
  input  logic    dds_valid_i,
  output iq_t     dac_iq_o,
  output iq_t     adc_iq_o,
  output logic    adc_valid_o
);

  iq_t        dac_r;
  iq_t        dac_rr;
  iq_t        adc_r;
  iq_t        adc_rr;
  logic [3:0] valid_sr;

  // two stages towards the DAC, two more back from the ADC
  always_ff @(posedge clk_245_76MHz) begin
    dac_r  <= {dds_i_i, dds_q_i};
    dac_rr <= dac_r;
    adc_r  <= dac_rr;
    adc_rr <= adc_r;
  end

  // valid follows the samples through all four stages
  always_ff @(posedge clk_245_76MHz) begin
    valid_sr <= {valid_sr[2:0], dds_valid_i};
  end

  assign dac_iq_o    = dac_rr;
  assign adc_iq_o    = adc_rr;
  assign adc_valid_o = valid_sr[3];

endmodule

// ==== capture_ctrl.sv ====
`timescale 1ns/10ps

module capture_ctrl
  import radar_pkg::*;
(
  input  logic   clk_245_76MHz,
  input  logic   cpu_reset,
  input  logic   adc_enable_i,
  input  logic   chirp_init_i,
  input  logic   adc_valid_i,
  output logic   wr_en_o,
  output logic   first_o,
  output logic   last_o,
  output count_t sample_count_o,
  output count_t timestamp_o
);

  logic       en_r;
  logic       en_settled;
  logic       first_r;
  logic [3:0] settle_cnt;
  logic       settled;
  count_t     sample_cnt;
  count_t     ts_cnt;

  assign settled = (settle_cnt == '0);

  // settle window restarts on chirp start and on a falling enable
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      settle_cnt <= '0;
    end else if (chirp_init_i || (en_r && !adc_enable_i)) begin
      settle_cnt <= 4'(SETTLE_CYCLES);
    end else if (!settled) begin
      settle_cnt <= settle_cnt - 1'b1;
    end
  end

  // enable is frozen while the window is open
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_r       <= 1'b0;
      en_settled <= 1'b0;
      first_r    <= 1'b0;
    end else begin
      en_r <= adc_enable_i;
      if (settled) begin
        en_settled <= en_r;
      end
      first_r <= settled && en_r && !en_settled;
    end
  end

  assign first_o = first_r;
  // settled enable about to drop
  assign last_o  = settled && en_settled && !en_r;

  // marker cycles carry no sample
  assign wr_en_o = adc_valid_i && en_settled && !first_r && !last_o;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt <= '0;
    end else if (wr_en_o) begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  // free running
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      ts_cnt <= '0;
    end else begin
      ts_cnt <= ts_cnt + 1'b1;
    end
  end

  assign sample_count_o = sample_cnt;
  assign timestamp_o    = ts_cnt;

  a_markers_exclusive: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      !(first_o && last_o)
  );

endmodule

// ==== word_router.sv ====
`timescale 1ns/10ps

module word_router
  import radar_pkg::*;
(
  input  logic      clk_245_76MHz,
  input  logic      cpu_reset,
  input  route_t    route_lower_i,
  input  route_t    route_upper_i,
  input  iq_t       adc_iq_i,
  input  iq_t       dac_iq_i,
  input  count_t    sample_count_i,
  input  count_t    timestamp_i,
  input  logic      wr_en_i,
  input  logic      first_i,
  input  logic      last_i,
  output cap_word_t cap_word_o,
  output logic      cap_last_o,
  output logic      cap_wr_o
);

  logic [31:0] lower;
  logic [31:0] upper;
  logic        marker;

  function automatic logic [31:0] pick_half(
    input route_t route,
    input iq_t    adc,
    input iq_t    dac,
    input count_t count,
    input count_t stamp
  );
    case (route)
      route_adc:          return adc;
      route_dac:          return dac;
      route_sample_count: return count;
      default:            return stamp;
    endcase
  endfunction

  always_comb begin
    lower = pick_half(route_lower_i, adc_iq_i, dac_iq_i, sample_count_i, timestamp_i);
    upper = pick_half(route_upper_i, adc_iq_i, dac_iq_i, sample_count_i, timestamp_i);
  end

  assign marker = first_i || last_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      cap_wr_o   <= 1'b0;
      cap_last_o <= 1'b0;
    end else begin
      // markers go out even when no sample is valid
      cap_wr_o   <= wr_en_i || marker;
      cap_last_o <= last_i;
    end
  end

  // marker layout is timestamp over sample count
  always_ff @(posedge clk_245_76MHz) begin
    if (marker) begin
      cap_word_o <= {timestamp_i, sample_count_i};
    end else begin
      cap_word_o <= {upper, lower};
    end
  end

endmodule

// ==== stream_buffer.sv ====
`timescale 1ns/10ps

module stream_buffer
  import radar_pkg::*;
(
  input  logic      clk_245_76MHz,
  input  logic      cpu_reset,
  input  logic      wr_i,
  input  cap_word_t word_i,
  input  logic      last_i,
  input  logic      tready_i,
  output cap_word_t tdata_o,
  output logic      tvalid_o,
  output logic      tlast_o,
  output logic      overflow_o
);

  cap_word_t         mem [BUF_DEPTH];
  logic              last_mem [BUF_DEPTH];
  logic [BUF_AW-1:0] wr_ptr;
  logic [BUF_AW-1:0] rd_ptr;
  logic [BUF_AW:0]   fill;
  logic              full;
  logic              push;
  logic              pop;

  assign full = (fill == (BUF_AW + 1)'(BUF_DEPTH));
  // a write into a full buffer is dropped
  assign push = wr_i && !full;
  assign pop  = tvalid_o && tready_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      mem[wr_ptr]      <= word_i;
      last_mem[wr_ptr] <= last_i;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      // sticky until reset
      if (wr_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // head of queue shows directly
  assign tvalid_o = (fill != '0);
  assign tdata_o  = mem[rd_ptr];
  assign tlast_o  = last_mem[rd_ptr];

  a_hold_while_stalled: assert property (
    @(posedge clk_245_76MHz) disable iff (cpu_reset)
      (tvalid_o && !tready_i) |=> (tvalid_o && $stable(tdata_o) && $stable(tlast_o))
  );

endmodule

// ==== chirp_capture_top.sv ====
`timescale 1ns/10ps

module chirp_capture_top
  import radar_pkg::*;
(
  input  logic      clk_245_76MHz,
  input  logic      cpu_reset,
  input  logic      chirp_init_i,
  input  logic      chirp_enable_i,
  input  phase_t    chirp_freq_offset_i,
  input  phase_t    chirp_freq_step_i,
  input  count_t    chirp_count_max_i,
  output logic      chirp_ready_o,
  output logic      chirp_active_o,
  output logic      chirp_done_o,
  input  logic      adc_enable_i,
  input  route_t    route_lower_i,
  input  route_t    route_upper_i,
  output cap_word_t cap_tdata_o,
  output logic      cap_tvalid_o,
  output logic      cap_tlast_o,
  input  logic      cap_tready_i,
  output logic      buf_overflow_o
);

  sample_t   dds_i;
  sample_t   dds_q;
  logic      dds_valid;
  iq_t       dac_iq;
  iq_t       adc_iq;
  logic      adc_valid;
  logic      wr_en;
  logic      is_first;
  logic      is_last;
  count_t    sample_count;
  count_t    timestamp;
  cap_word_t cap_word;
  logic      cap_last;
  logic      cap_wr;

  chirp_gen u_chirp_gen (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .chirp_init_i   (chirp_init_i),
    .chirp_enable_i (chirp_enable_i),
    .freq_offset_i  (chirp_freq_offset_i),
    .freq_step_i    (chirp_freq_step_i),
    .count_max_i    (chirp_count_max_i),
    .dds_i_o        (dds_i),
    .dds_q_o        (dds_q),
    .dds_valid_o    (dds_valid),
    .chirp_ready_o  (chirp_ready_o),
    .chirp_active_o (chirp_active_o),
    .chirp_done_o   (chirp_done_o)
  );

  // stands in for the converter board
  loopback_delay u_loopback_delay (
    .clk_245_76MHz (clk_245_76MHz),
    .dds_i_i       (dds_i),
    .dds_q_i       (dds_q),
    .dds_valid_i   (dds_valid),
    .dac_iq_o      (dac_iq),
    .adc_iq_o      (adc_iq),
    .adc_valid_o   (adc_valid)
  );

  capture_ctrl u_capture_ctrl (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .adc_enable_i   (adc_enable_i),
    .chirp_init_i   (chirp_init_i),
    .adc_valid_i    (adc_valid),
    .wr_en_o        (wr_en),
    .first_o        (is_first),
    .last_o         (is_last),
    .sample_count_o (sample_count),
    .timestamp_o    (timestamp)
  );

  word_router u_word_router (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .route_lower_i  (route_lower_i),
    .route_upper_i  (route_upper_i),
    .adc_iq_i       (adc_iq),
    .dac_iq_i       (dac_iq),
    .sample_count_i (sample_count),
    .timestamp_i    (timestamp),
    .wr_en_i        (wr_en),
    .first_i        (is_first),
    .last_i         (is_last),
    .cap_word_o     (cap_word),
    .cap_last_o     (cap_last),
    .cap_wr_o       (cap_wr)
  );

  stream_buffer u_stream_buffer (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .wr_i          (cap_wr),
    .word_i        (cap_word),
    .last_i        (cap_last),
    .tready_i      (cap_tready_i),
    .tdata_o       (cap_tdata_o),
    .tvalid_o      (cap_tvalid_o),
    .tlast_o       (cap_tlast_o),
    .overflow_o    (buf_overflow_o)
  );

endmodule

// ==== tb_chirp_capture.sv ====
`timescale 1ns/10ps

module tb_chirp_capture
  import radar_pkg::*;
();

  localparam int WAIT_LIMIT = 1000;

  logic      clk_245_76MHz = 1'b0;
  logic      cpu_reset;
  logic      chirp_init_i;
  logic      chirp_enable_i;
  phase_t    chirp_freq_offset_i;
  phase_t    chirp_freq_step_i;
  count_t    chirp_count_max_i;
  logic      chirp_ready_o;
  logic      chirp_active_o;
  logic      chirp_done_o;
  logic      adc_enable_i;
  route_t    route_lower_i;
  route_t    route_upper_i;
  cap_word_t cap_tdata_o;
  logic      cap_tvalid_o;
  logic      cap_tlast_o;
  logic      cap_tready_i;
  logic      buf_overflow_o;

  int        mismatches = 0;
  int        failures = 0;
  int        timeouts = 0;
  bit        stall_on = 1'b0;
  cap_word_t words[$];
  logic      lasts[$];

  chirp_capture_top i_dut (
    .clk_245_76MHz       (clk_245_76MHz),
    .cpu_reset           (cpu_reset),
    .chirp_init_i        (chirp_init_i),
    .chirp_enable_i      (chirp_enable_i),
    .chirp_freq_offset_i (chirp_freq_offset_i),
    .chirp_freq_step_i   (chirp_freq_step_i),
    .chirp_count_max_i   (chirp_count_max_i),
    .chirp_ready_o       (chirp_ready_o),
    .chirp_active_o      (chirp_active_o),
    .chirp_done_o        (chirp_done_o),
    .adc_enable_i        (adc_enable_i),
    .route_lower_i       (route_lower_i),
    .route_upper_i       (route_upper_i),
    .cap_tdata_o         (cap_tdata_o),
    .cap_tvalid_o        (cap_tvalid_o),
    .cap_tlast_o         (cap_tlast_o),
    .cap_tready_i        (cap_tready_i),
    .buf_overflow_o      (buf_overflow_o)
  );

  always #20 clk_245_76MHz = ~clk_245_76MHz;

  // handshake is stable at the falling edge before the transferring rising edge
  always @(negedge clk_245_76MHz) begin
    if (!cpu_reset && cap_tvalid_o && cap_tready_i) begin
      words.push_back(cap_tdata_o);
      lasts.push_back(cap_tlast_o);
    end
  end

  // one cycle with inputs changing 2 ns after the edge
  task automatic tick();
    @(posedge clk_245_76MHz);
    #2;
    if (stall_on) begin
      cap_tready_i = (($urandom % 4) != 0);
    end else begin
      cap_tready_i = 1'b1;
    end
  endtask

  task automatic compare_word(input string test, input cap_word_t expected,
                              input cap_word_t actual);
    if (expected !== actual) begin
      mismatches++;
      $display("Mismatch in %s: expected %h, actual %h", test, expected, actual);
    end
  endtask

  task automatic compare_count(input string test, input count_t expected,
                               input count_t actual);
    if (expected !== actual) begin
      mismatches++;
      $display("Mismatch in %s: expected %0d, actual %0d", test, expected, actual);
    end
  endtask

  task automatic compare_sample(input string test, input sample_t expected,
                                input sample_t actual);
    if (expected !== actual) begin
      mismatches++;
      $display("Mismatch in %s: expected %0d, actual %0d", test, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("Error counts: %0d mismatches, %0d failed checks, %0d timeouts",
             mismatches, failures, timeouts);
    if (mismatches == 0 && failures == 0 && timeouts == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    timeouts++;
    $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    finish_run();
  endtask

  task automatic apply_reset();
    repeat (10) tick();
    cpu_reset = 1'b0;
    tick();
    if (!chirp_ready_o || chirp_active_o || chirp_done_o || cap_tvalid_o || buf_overflow_o) begin
      failures++;
      $display("Control outputs are not in their idle state after reset");
    end
  endtask

  // one capture window around one chirp with the words landing in the queues
  task automatic capture_burst(input count_t length, input phase_t offset, input phase_t step);
    int guard;
    words.delete();
    lasts.delete();
    chirp_count_max_i   = length;
    chirp_freq_offset_i = offset;
    chirp_freq_step_i   = step;
    adc_enable_i        = 1'b1;
    repeat (4) tick();
    chirp_init_i = 1'b1;
    tick();
    chirp_init_i = 1'b0;
    guard = 0;
    while (!chirp_done_o && guard < WAIT_LIMIT) begin
      tick();
      guard++;
    end
    if (guard >= WAIT_LIMIT) begin
      abort_on_timeout("end of chirp");
    end else begin
      // let the loopback and router drain
      repeat (8) tick();
      adc_enable_i = 1'b0;
      guard = 0;
      while (!(lasts.size() > 0 && lasts[$] === 1'b1) && guard < WAIT_LIMIT) begin
        tick();
        guard++;
      end
      if (guard >= WAIT_LIMIT) begin
        abort_on_timeout("last marker word on the stream");
      end else begin
        repeat (4) tick();
      end
    end
  endtask

  // first marker, length data words, last marker
  task automatic check_framing(input string test, input int length, output bit ok);
    int n;
    n = words.size();
    ok = (n == length + 2);
    compare_count(test, count_t'(length), count_t'(n - 2));
    if (ok) begin
      if (lasts[0] !== 1'b0) begin
        failures++;
        $display("%s: the first marker word carries tlast", test);
      end
      if (lasts[n-1] !== 1'b1) begin
        failures++;
        $display("%s: the final word of the burst has no tlast", test);
      end
      for (int i = 1; i < n - 1; i++) begin
        if (lasts[i] !== 1'b0) begin
          failures++;
          $display("%s: tlast is set on data word %0d", test, i - 1);
        end
      end
    end
  endtask

  // marker words carry the sample count and each sample adds one
  task automatic check_count_sequence(input string test, input int length);
    bit     ok;
    count_t first_cnt;
    count_t expect_cnt;
    check_framing(test, length, ok);
    if (ok) begin
      first_cnt = words[0][31:0];
      for (int k = 0; k < length; k++) begin
        expect_cnt = first_cnt + count_t'(k);
        compare_word(test, {expect_cnt, expect_cnt}, words[k+1]);
      end
      compare_count(test, first_cnt + count_t'(length), words[length+1][31:0]);
      // marker timestamps enclose the cycles of all data words
      if ((words[length+1][63:32] - words[0][63:32]) <= count_t'(length)) begin
        failures++;
        $display("%s: the marker timestamps lie less than %0d cycles apart",
                 test, length + 1);
      end
    end
  endtask

  task automatic test_chirp_length();
    int guard;
    int active_cycles;
    int done_pulses;
    chirp_count_max_i = 40;
    chirp_init_i = 1'b1;
    tick();
    chirp_init_i = 1'b0;
    active_cycles = 0;
    done_pulses = 0;
    guard = 0;
    while (!(chirp_ready_o && done_pulses > 0) && guard < WAIT_LIMIT) begin
      if (chirp_active_o) begin
        active_cycles++;
      end
      if (chirp_done_o) begin
        done_pulses++;
      end
      tick();
      guard++;
    end
    if (guard >= WAIT_LIMIT) begin
      abort_on_timeout("return to ready after the chirp");
    end else begin
      compare_count("chirp_length", 40, count_t'(active_cycles));
      compare_count("chirp_length", 1, count_t'(done_pulses));
    end
  endtask

  task automatic test_chirp_law();
    bit      ok;
    phase_t  step;
    sample_t d_prev;
    sample_t d_cur;
    step = 32'h0005_0000;
    route_lower_i = route_adc;
    route_upper_i = route_timestamp;
    capture_burst(24, 32'h0123_0000, step);
    check_framing("chirp_law", 24, ok);
    if (ok) begin
      // second difference of I is the step in sample units
      for (int k = 2; k < 24; k++) begin
        d_prev = sample_t'(words[k][31:16]) - sample_t'(words[k-1][31:16]);
        d_cur  = sample_t'(words[k+1][31:16]) - sample_t'(words[k][31:16]);
        compare_sample("chirp_law", sample_t'(step[31:16]), sample_t'(d_cur - d_prev));
      end
      // one sample per cycle against the free running timestamp
      for (int k = 1; k < 24; k++) begin
        compare_count("chirp_law", count_t'(1),
                      count_t'(words[k+1][63:32] - words[k][63:32]));
      end
    end
  endtask

  task automatic test_dac_adc_lag();
    bit ok;
    route_lower_i = route_adc;
    route_upper_i = route_dac;
    capture_burst(16, 32'h0200_0000, 32'h0010_0000);
    check_framing("dac_adc_lag", 16, ok);
    if (ok) begin
      for (int k = 2; k < 16; k++) begin
        compare_sample("dac_adc_lag", sample_t'(words[k-1][63:48]), sample_t'(words[k+1][31:16]));
        compare_sample("dac_adc_lag", sample_t'(words[k-1][47:32]), sample_t'(words[k+1][15:0]));
      end
    end
  endtask

  task automatic test_markers();
    route_lower_i = route_sample_count;
    route_upper_i = route_sample_count;
    capture_burst(20, 32'h0100_0000, 32'h0002_0000);
    check_count_sequence("markers", 20);
  endtask

  task automatic test_back_pressure();
    route_lower_i = route_sample_count;
    route_upper_i = route_sample_count;
    stall_on = 1'b1;
    capture_burst(10, 32'h0300_0000, 32'h0001_0000);
    stall_on = 1'b0;
    check_count_sequence("back_pressure", 10);
    if (buf_overflow_o !== 1'b0) begin
      failures++;
      $display("back_pressure: the buffer reported an overflow");
    end
  endtask

  initial begin
    void'($urandom(79292));
    cpu_reset           = 1'b1;
    chirp_init_i        = 1'b0;
    chirp_enable_i      = 1'b0;
    chirp_freq_offset_i = '0;
    chirp_freq_step_i   = '0;
    chirp_count_max_i   = '0;
    adc_enable_i        = 1'b0;
    route_lower_i       = route_adc;
    route_upper_i       = route_adc;
    cap_tready_i        = 1'b1;
    apply_reset();
    chirp_enable_i = 1'b1;
    test_chirp_length();
    test_chirp_law();
    test_dac_adc_lag();
    test_markers();
    test_back_pressure();
    finish_run();
  end

endmodule

// ==== verilog.f ====
radar_pkg.sv
chirp_gen.sv
loopback_delay.sv
capture_ctrl.sv
word_router.sv
stream_buffer.sv
chirp_capture_top.sv
tb_chirp_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the chirp capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_chirp_capture -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_chirp_capture > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "Simulation exited with an error status"
fi
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
